// File: pseudo_pkg.sv
`default_nettype none

package pseudo_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int WIDTH   = 16;               // Data bits per word
  localparam int PARITY  = 1;                // Even parity bit per word
  localparam int MEMWDTH = WIDTH + PARITY;   // Stored slot
  localparam int NUMWRDS = 3;                // Words per SRAM row
  localparam int BITWRDS = 2;
  localparam int ROWWDTH = NUMWRDS * MEMWDTH;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Physical row, seen as one vector or as word slots
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef union packed {
    logic [ROWWDTH-1:0]              flat;
    logic [NUMWRDS-1:0][MEMWDTH-1:0] slot;  // Parity on top of each slot
  } row_t;

endpackage

`default_nettype wire

// File: np2_addr.sv
`default_nettype none

module np2_addr #(
  parameter int  NUMADDR = 96,
  parameter int  NUMSROW = 32,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int BITSROW = $clog2(NUMSROW)
) (
  input  logic [BITADDR-1:0]             vaddr,
  output logic [pseudo_pkg::BITWRDS-1:0] vbadr,
  output logic [BITSROW-1:0]             vradr
);
  import pseudo_pkg::*;

  // Slot within the row, then the row itself
  assign vbadr = BITWRDS'(vaddr % NUMWRDS);
  assign vradr = BITSROW'(vaddr / NUMWRDS);

  // Every row must hold NUMWRDS words, so a bad address would alias
  always_comb begin
    if (!$isunknown(vaddr)) begin
      assert (int'(vaddr) < NUMADDR)
        else $error("np2_addr: address %0d beyond %0d words", vaddr, NUMADDR);
    end
  end

endmodule

`default_nettype wire

// File: align_pseudo.sv
`default_nettype none

module align_pseudo #(
  parameter int  NUMVROW    = 96,
  parameter int  NUMVBNK    = 2,
  parameter int  SRAM_DELAY = 2,
  parameter int  FLOPMEM    = 1,
  localparam int BITVROW    = $clog2(NUMVROW),
  localparam int BITVBNK    = $clog2(NUMVBNK),
  localparam int NUMSROW    = (NUMVROW + pseudo_pkg::NUMWRDS - 1) / pseudo_pkg::NUMWRDS,
  localparam int BITSROW    = $clog2(NUMSROW),
  localparam int BITPADR    = pseudo_pkg::BITWRDS + BITSROW
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         write,
  input  logic [BITVBNK-1:0]           wr_bnk,
  input  logic [BITVROW-1:0]           wr_adr,
  input  logic [pseudo_pkg::WIDTH-1:0] din,
  input  logic                         err_inject,
  input  logic                         read,
  input  logic [BITVBNK-1:0]           rd_bnk,
  input  logic [BITVROW-1:0]           rd_adr,
  output logic [pseudo_pkg::WIDTH-1:0] dout,
  output logic                         serr,
  output logic [BITPADR-1:0]           padr,
  output logic [BITVBNK-1:0]           al_bnk,
  output logic                         mem_write,
  output logic [BITVBNK-1:0]           mem_wr_bnk,
  output logic [BITSROW-1:0]           mem_wr_adr,
  output pseudo_pkg::row_t             mem_bw,
  output pseudo_pkg::row_t             mem_din,
  output logic                         mem_read,
  output logic [BITVBNK-1:0]           mem_rd_bnk,
  output logic [BITSROW-1:0]           mem_rd_adr,
  input  pseudo_pkg::row_t             mem_dout
);
  import pseudo_pkg::*;

  localparam int LAT = SRAM_DELAY + FLOPMEM;

  logic [BITWRDS-1:0] wr_wadr;
  logic [BITSROW-1:0] wr_radr;
  logic [BITWRDS-1:0] rd_wadr;
  logic [BITSROW-1:0] rd_radr;
  logic               wr_par;

  np2_addr #(.NUMADDR(NUMVROW), .NUMSROW(NUMSROW)) i_wr_split (
    .vaddr (wr_adr),
    .vbadr (wr_wadr),
    .vradr (wr_radr)
  );

  np2_addr #(.NUMADDR(NUMVROW), .NUMSROW(NUMSROW)) i_rd_split (
    .vaddr (rd_adr),
    .vbadr (rd_wadr),
    .vradr (rd_radr)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wr_par = (PARITY != 0) && ((^din) ^ err_inject);  // Flipped on inject

  always_comb begin
    mem_bw.flat  = ROWWDTH'({MEMWDTH{1'b1}}) << (wr_wadr * MEMWDTH);
    mem_din.flat = ROWWDTH'(MEMWDTH'({wr_par, din})) << (wr_wadr * MEMWDTH);
  end

  assign mem_write  = write;
  assign mem_wr_bnk = wr_bnk;
  assign mem_wr_adr = wr_radr;

  assign mem_read   = read;
  assign mem_rd_bnk = rd_bnk;
  assign mem_rd_adr = rd_radr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read coordinates follow the data through the memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [BITVBNK-1:0] bnk_q  [LAT];
  logic [BITWRDS-1:0] wadr_q [LAT];
  logic [BITSROW-1:0] radr_q [LAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LAT; i++) begin
        bnk_q[i]  <= '0;
        wadr_q[i] <= '0;
        radr_q[i] <= '0;
      end
    end else begin
      bnk_q[0]  <= rd_bnk;
      wadr_q[0] <= rd_wadr;
      radr_q[0] <= rd_radr;
      for (int i = 1; i < LAT; i++) begin
        bnk_q[i]  <= bnk_q[i-1];
        wadr_q[i] <= wadr_q[i-1];
        radr_q[i] <= radr_q[i-1];
      end
    end
  end

  row_t               rd_row;
  logic [MEMWDTH-1:0] rd_slot;

  if (FLOPMEM != 0) begin : g_flop
    row_t dout_q;
    always_ff @(posedge clk) dout_q <= mem_dout;
    assign rd_row = dout_q;
  end else begin : g_noflop
    assign rd_row = mem_dout;
  end

  assign rd_slot = rd_row.slot[wadr_q[LAT-1]];
  assign dout    = rd_slot[WIDTH-1:0];
  assign serr    = (PARITY != 0) && (^rd_slot);
  assign padr    = {wadr_q[LAT-1], radr_q[LAT-1]};  // Slot above row
  assign al_bnk  = bnk_q[LAT-1];

endmodule

`default_nettype wire

// File: read_arbiter.sv
`default_nettype none

module read_arbiter #(
  parameter int  LAT     = 3,
  parameter int  NUMVROW = 96,
  parameter int  NUMVBNK = 2,
  localparam int BITVROW = $clog2(NUMVROW),
  localparam int BITVBNK = $clog2(NUMVBNK)
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               read,
  input  logic [BITVBNK-1:0] rd_bnk,
  input  logic [BITVROW-1:0] rd_adr,
  input  logic               scrub_read,
  input  logic [BITVBNK-1:0] scrub_bnk,
  input  logic [BITVROW-1:0] scrub_adr,
  output logic               scrub_gnt,
  output logic               arb_read,
  output logic [BITVBNK-1:0] arb_bnk,
  output logic [BITVROW-1:0] arb_adr,
  output logic               rd_vld,
  output logic               scrub_vld
);

  logic [LAT-1:0] vld_q;
  logic [LAT-1:0] own_q;  // Set for scrubber reads

  // Host always wins
  assign scrub_gnt = scrub_read && !read;
  assign arb_read  = read || scrub_read;
  assign arb_bnk   = read ? rd_bnk : scrub_bnk;
  assign arb_adr   = read ? rd_adr : scrub_adr;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
      own_q <= '0;
    end else begin
      vld_q <= LAT'({vld_q, arb_read});
      own_q <= LAT'({own_q, scrub_gnt});
    end
  end

  assign rd_vld    = vld_q[LAT-1] && !own_q[LAT-1];
  assign scrub_vld = vld_q[LAT-1] && own_q[LAT-1];

  a_one_owner: assert property (@(posedge clk) disable iff (rst) !(rd_vld && scrub_vld))
    else $error("read_arbiter: return claimed by host and scrubber");

  // Host sees a fixed latency whatever the scrubber does
  a_host_lat: assert property (@(posedge clk) disable iff (rst) read |-> ##LAT rd_vld)
    else $error("read_arbiter: host read lost or late");

  a_scrub_lat: assert property (@(posedge clk) disable iff (rst) scrub_gnt |-> ##LAT scrub_vld)
    else $error("read_arbiter: scrub read lost or late");

endmodule

`default_nettype wire

// File: parity_scrubber.sv
`default_nettype none

module parity_scrubber #(
  parameter int  NUMVROW = 96,
  parameter int  NUMVBNK = 2,
  localparam int BITVROW = $clog2(NUMVROW),
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int NUMSROW = (NUMVROW + pseudo_pkg::NUMWRDS - 1) / pseudo_pkg::NUMWRDS,
  localparam int BITSROW = $clog2(NUMSROW),
  localparam int BITPADR = pseudo_pkg::BITWRDS + BITSROW
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               scrub_en,
  input  logic               scrub_gnt,
  input  logic               scrub_vld,
  input  logic               al_serr,
  input  logic [BITPADR-1:0] al_padr,
  input  logic [BITVBNK-1:0] al_bnk,
  output logic               scrub_read,
  output logic [BITVBNK-1:0] scrub_bnk,
  output logic [BITVROW-1:0] scrub_adr,
  output logic [15:0]        scrub_err_cnt,
  output logic [BITVBNK-1:0] scrub_err_bnk,
  output logic [BITPADR-1:0] scrub_err_padr,
  output logic               scrub_done
);
  import pseudo_pkg::*;

  localparam logic [BITWRDS-1:0] LAST_SLOT = BITWRDS'((NUMVROW - 1) % NUMWRDS);
  localparam logic [BITSROW-1:0] LAST_ROW  = BITSROW'((NUMVROW - 1) / NUMWRDS);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_RUN   = 2'd1;  // Issuing reads
  localparam logic [1:0] S_DRAIN = 2'd2;  // Waiting for the last return
  localparam logic [1:0] S_HOLD  = 2'd3;  // Result kept until scrub_en drops

  logic [1:0] state;
  logic       last_adr;
  logic       last_bnk;
  logic       last_ret;

  assign last_adr   = scrub_adr == BITVROW'(NUMVROW - 1);
  assign last_bnk   = scrub_bnk == BITVBNK'(NUMVBNK - 1);
  assign last_ret   = scrub_vld && (al_bnk == BITVBNK'(NUMVBNK - 1)) &&
                      (al_padr == {LAST_SLOT, LAST_ROW});
  assign scrub_read = (state == S_RUN) && scrub_en;

  // One sweep per scrub_en assertion
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      scrub_bnk  <= '0;
      scrub_adr  <= '0;
      scrub_done <= 1'b0;
    end else begin
      scrub_done <= (state == S_DRAIN) && last_ret;
      case (state)
        S_IDLE: if (scrub_en) state <= S_RUN;
        S_RUN: begin
          if (scrub_gnt) begin
            if (!last_adr) begin
              scrub_adr <= scrub_adr + 1'b1;
            end else begin
              scrub_adr <= '0;
              scrub_bnk <= last_bnk ? '0 : scrub_bnk + 1'b1;
              if (last_bnk) state <= S_DRAIN;
            end
          end
        end
        S_DRAIN: if (last_ret) state <= S_HOLD;
        default: if (!scrub_en) state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scrub_err_cnt <= '0;
    end else if (state == S_IDLE && scrub_en) begin
      scrub_err_cnt <= '0;
    end else if (scrub_vld && al_serr) begin
      scrub_err_cnt <= scrub_err_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (scrub_vld && al_serr) begin
      scrub_err_bnk  <= al_bnk;
      scrub_err_padr <= al_padr;
    end
  end

endmodule

`default_nettype wire

// File: row_sram.sv
`default_nettype none

module row_sram #(
  parameter int  NUMVBNK    = 2,
  parameter int  NUMSROW    = 32,
  parameter int  SRAM_DELAY = 2,
  localparam int BITVBNK    = $clog2(NUMVBNK),
  localparam int BITSROW    = $clog2(NUMSROW)
) (
  input  logic               clk,
  input  logic               mem_write,
  input  logic [BITVBNK-1:0] mem_wr_bnk,
  input  logic [BITSROW-1:0] mem_wr_adr,
  input  pseudo_pkg::row_t   mem_bw,
  input  pseudo_pkg::row_t   mem_din,
  input  logic               mem_read,
  input  logic [BITVBNK-1:0] mem_rd_bnk,
  input  logic [BITSROW-1:0] mem_rd_adr,
  output pseudo_pkg::row_t   mem_dout
);
  import pseudo_pkg::*;

  row_t mem  [NUMVBNK][NUMSROW];
  row_t rd_q [SRAM_DELAY];

  // Bit masked write leaves other slots of the row untouched
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_wr_bnk][mem_wr_adr] <= (mem[mem_wr_bnk][mem_wr_adr].flat & ~mem_bw.flat) |
                                     (mem_din.flat & mem_bw.flat);
    end
  end

  always_ff @(posedge clk) begin
    if (mem_read) begin
      rd_q[0] <= mem[mem_rd_bnk][mem_rd_adr];  // Holds when idle
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_q[i] <= rd_q[i-1];
    end
  end

  assign mem_dout = rd_q[SRAM_DELAY-1];

  // Row addresses come out of the aligner's divider
  a_row_range: assert property (@(posedge clk)
    (!mem_write || int'(mem_wr_adr) < NUMSROW) && (!mem_read || int'(mem_rd_adr) < NUMSROW))
    else $error("row_sram: row address beyond %0d", NUMSROW);

endmodule

`default_nettype wire

// File: scrub_mem_top.sv
`default_nettype none

module scrub_mem_top #(
  parameter int  NUMVROW    = 96,
  parameter int  NUMVBNK    = 2,
  parameter int  SRAM_DELAY = 2,
  parameter int  FLOPMEM    = 1,
  localparam int BITVROW    = $clog2(NUMVROW),
  localparam int BITVBNK    = $clog2(NUMVBNK),
  localparam int NUMSROW    = (NUMVROW + pseudo_pkg::NUMWRDS - 1) / pseudo_pkg::NUMWRDS,
  localparam int BITSROW    = $clog2(NUMSROW),
  localparam int BITPADR    = pseudo_pkg::BITWRDS + BITSROW
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         write,
  input  logic [BITVBNK-1:0]           wr_bnk,
  input  logic [BITVROW-1:0]           wr_adr,
  input  logic [pseudo_pkg::WIDTH-1:0] din,
  input  logic                         err_inject,
  input  logic                         read,
  input  logic [BITVBNK-1:0]           rd_bnk,
  input  logic [BITVROW-1:0]           rd_adr,
  output logic                         rd_vld,
  output logic [pseudo_pkg::WIDTH-1:0] dout,
  output logic                         serr,
  output logic [BITPADR-1:0]           padr,
  input  logic                         scrub_en,
  output logic [15:0]                  scrub_err_cnt,
  output logic [BITVBNK-1:0]           scrub_err_bnk,
  output logic [BITPADR-1:0]           scrub_err_padr,
  output logic                         scrub_done
);
  import pseudo_pkg::*;

  logic               scrub_read;
  logic               scrub_gnt;
  logic               scrub_vld;
  logic [BITVBNK-1:0] scrub_bnk;
  logic [BITVROW-1:0] scrub_adr;
  logic               arb_read;
  logic [BITVBNK-1:0] arb_bnk;
  logic [BITVROW-1:0] arb_adr;
  logic [WIDTH-1:0]   al_dout;
  logic               al_serr;
  logic [BITPADR-1:0] al_padr;
  logic [BITVBNK-1:0] al_bnk;
  logic               mem_write;
  logic [BITVBNK-1:0] mem_wr_bnk;
  logic [BITSROW-1:0] mem_wr_adr;
  row_t               mem_bw;
  row_t               mem_din;
  logic               mem_read;
  logic [BITVBNK-1:0] mem_rd_bnk;
  logic [BITSROW-1:0] mem_rd_adr;
  row_t               mem_dout;

  // Returned word qualified by rd_vld alone
  assign dout = al_dout;
  assign serr = al_serr;
  assign padr = al_padr;

  read_arbiter #(
    .LAT     (SRAM_DELAY + FLOPMEM),
    .NUMVROW (NUMVROW),
    .NUMVBNK (NUMVBNK)
  ) i_arb (.*);

  parity_scrubber #(.NUMVROW(NUMVROW), .NUMVBNK(NUMVBNK)) i_scrub (.*);

  align_pseudo #(
    .NUMVROW    (NUMVROW),
    .NUMVBNK    (NUMVBNK),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPMEM    (FLOPMEM)
  ) i_align (
    .read   (arb_read),
    .rd_bnk (arb_bnk),
    .rd_adr (arb_adr),
    .dout   (al_dout),
    .serr   (al_serr),
    .padr   (al_padr),
    .*
  );

  row_sram #(.NUMVBNK(NUMVBNK), .NUMSROW(NUMSROW), .SRAM_DELAY(SRAM_DELAY)) i_sram (.*);

endmodule

`default_nettype wire

// File: tb_scrub_mem.sv
`default_nettype none

module tb_scrub_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUMVROW = 96;
  localparam int NUMVBNK = 2;
  localparam int BITPADR = 7;
  localparam logic WR = 1'b0;
  localparam logic RD = 1'b1;

  typedef struct packed {
    logic        rd;
    logic        bnk;
    logic [6:0]  adr;
    logic [15:0] data;  // Written word or expected dout
    logic        inj;   // Inject flag on write and expected serr on read
  } step_t;

  typedef struct packed {
    logic [15:0]        data;
    logic               serr;
    logic [BITPADR-1:0] padr;
  } ret_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam step_t STEPS [22] = '{
    '{WR, 1'b0, 7'd15, 16'hA015, 1'b0},  // All three slots of row 5
    '{WR, 1'b0, 7'd16, 16'hB016, 1'b0},
    '{WR, 1'b0, 7'd17, 16'hC017, 1'b0},
    '{WR, 1'b1, 7'd15, 16'hD115, 1'b0},
    '{WR, 1'b1, 7'd16, 16'hE116, 1'b0},
    '{WR, 1'b1, 7'd17, 16'hF117, 1'b0},
    '{RD, 1'b0, 7'd15, 16'hA015, 1'b0},
    '{RD, 1'b0, 7'd16, 16'hB016, 1'b0},
    '{RD, 1'b0, 7'd17, 16'hC017, 1'b0},
    '{RD, 1'b1, 7'd15, 16'hD115, 1'b0},
    '{RD, 1'b1, 7'd16, 16'hE116, 1'b0},
    '{RD, 1'b1, 7'd17, 16'hF117, 1'b0},
    '{WR, 1'b0, 7'd40, 16'h5A5A, 1'b1},  // Inject then clean rewrite
    '{RD, 1'b0, 7'd40, 16'h5A5A, 1'b1},
    '{WR, 1'b0, 7'd40, 16'hA5A5, 1'b0},
    '{RD, 1'b0, 7'd40, 16'hA5A5, 1'b0},
    '{WR, 1'b0, 7'd7,  16'h0F0F, 1'b1},  // Left bad for the scrubber
    '{WR, 1'b1, 7'd50, 16'h1357, 1'b1},
    '{WR, 1'b1, 7'd95, 16'h8001, 1'b1},
    '{RD, 1'b0, 7'd7,  16'h0F0F, 1'b1},
    '{RD, 1'b1, 7'd50, 16'h1357, 1'b1},
    '{RD, 1'b1, 7'd95, 16'h8001, 1'b1}
  };

  logic               clk;
  logic               rst;
  logic               write;
  logic [0:0]         wr_bnk;
  logic [6:0]         wr_adr;
  logic [15:0]        din;
  logic               err_inject;
  logic               read;
  logic [0:0]         rd_bnk;
  logic [6:0]         rd_adr;
  logic               rd_vld;
  logic [15:0]        dout;
  logic               serr;
  logic [BITPADR-1:0] padr;
  logic               scrub_en;
  logic [15:0]        scrub_err_cnt;
  logic [0:0]         scrub_err_bnk;
  logic [BITPADR-1:0] scrub_err_padr;
  logic               scrub_done;

  logic [15:0] ref_data [NUMVBNK][NUMVROW];
  logic        ref_err  [NUMVBNK][NUMVROW];
  ret_t        exp_q[$];
  int          issue_q[$];
  int          cyc      = 0;
  int          done_cnt = 0;
  int          errors   = 0;
  int          checks   = 0;
  int          test_mark;
  string       test_name;
  logic [31:0] rng      = 32'h4ab2_f1b4;
  logic [31:0] r;

  scrub_mem_top #(
    .NUMVROW    (NUMVROW),
    .NUMVBNK    (NUMVBNK),
    .SRAM_DELAY (2),
    .FLOPMEM    (1)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // Slot above row with three words per row
  function automatic logic [BITPADR-1:0] padr_of(int adr);
    return {2'(adr % 3), 5'(adr / 3)};
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(bit ok, string what);
    checks++;
    assert (ok) else begin
      $display("Failure at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_mark = errors;
  endtask

  task automatic end_test();
    if (errors == test_mark) $display("Test %s: ok", test_name);
    else $display("Test %s: %0d failed checks", test_name, errors - test_mark);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host port drivers with one operation per clock
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic issue_write(int bnk, int adr, logic [15:0] data, logic inj);
    @(posedge clk);
    write      <= 1'b1;
    read       <= 1'b0;
    wr_bnk     <= 1'(bnk);
    wr_adr     <= 7'(adr);
    din        <= data;
    err_inject <= inj;
    ref_data[bnk][adr] = data;
    ref_err[bnk][adr]  = inj;
  endtask

  task automatic issue_read(int bnk, int adr, logic [15:0] data, logic exp_serr);
    @(posedge clk);
    write  <= 1'b0;
    read   <= 1'b1;
    rd_bnk <= 1'(bnk);
    rd_adr <= 7'(adr);
    exp_q.push_back(ret_t'({data, exp_serr, padr_of(adr)}));
  endtask

  task automatic idle();
    @(posedge clk);
    write      <= 1'b0;
    read       <= 1'b0;
    err_inject <= 1'b0;
  endtask

  task automatic apply_steps(int first, int last);
    for (int i = first; i <= last; i++) begin
      if (STEPS[i].rd == RD) begin
        issue_read(STEPS[i].bnk, STEPS[i].adr, STEPS[i].data, STEPS[i].inj);
      end else begin
        issue_write(STEPS[i].bnk, STEPS[i].adr, STEPS[i].data, STEPS[i].inj);
      end
    end
    idle();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    expect_true(exp_q.size() == 0, "host reads still outstanding after 20 cycles");
  endtask

  // Random host reads alongside the sweep when traffic is set
  task automatic run_sweep(bit traffic);
    int n;
    int start;
    int bnk;
    int adr;
    n = 0;
    start = done_cnt;
    while (done_cnt == start && n < 3000) begin
      r = next_rand();
      if (traffic && r[0]) begin
        bnk = int'(r[9]);
        adr = int'(r[8:2]) % NUMVROW;
        issue_read(bnk, adr, ref_data[bnk][adr], ref_err[bnk][adr]);
      end else begin
        idle();
      end
      n++;
    end
    idle();
    drain();
    expect_true(done_cnt != start, "scrub sweep did not end within 3000 cycles");
    @(negedge clk);
  endtask

  task automatic check_scrub();
    int cnt;
    int lb;
    int la;
    cnt = 0;
    lb  = 0;
    la  = 0;
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int a = 0; a < NUMVROW; a++) begin
        if (ref_err[b][a]) begin
          cnt++;
          lb = b;
          la = a;
        end
      end
    end
    check("scrub_err_cnt", scrub_err_cnt, cnt);
    check("scrub_err_bnk", scrub_err_bnk, lb);
    check("scrub_err_padr", scrub_err_padr, padr_of(la));
  endtask

  // Return monitor sampled mid cycle
  always @(negedge clk) begin
    ret_t e;
    if (rd_vld) begin
      expect_true(exp_q.size() > 0 && issue_q.size() > 0,
                  "rd_vld high with no read outstanding");
      if (exp_q.size() > 0 && issue_q.size() > 0) begin
        e = exp_q.pop_front();
        check("rd_vld latency", cyc - issue_q.pop_front(), 3);
        check("dout", dout, e.data);
        check("serr", serr, e.serr);
        check("padr", padr, e.padr);
      end
    end
    if (read && !rst) issue_q.push_back(cyc);
    if (scrub_done) done_cnt++;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst        = 1'b1;
    write      = 1'b0;
    wr_bnk     = '0;
    wr_adr     = '0;
    din        = '0;
    err_inject = 1'b0;
    read       = 1'b0;
    rd_bnk     = '0;
    rd_adr     = '0;
    scrub_en   = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    start_test("1 reset state");
    repeat (8) begin
      @(negedge clk);
      check("rd_vld", rd_vld, 0);
      check("scrub_done", scrub_done, 0);
      check("scrub_err_cnt", scrub_err_cnt, 0);
    end
    end_test();

    // Clean random contents everywhere
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int a = 0; a < NUMVROW; a++) begin
        r = next_rand();
        issue_write(b, a, r[15:0], 1'b0);
      end
    end
    idle();

    start_test("2 slot writes and pipelined reads");
    apply_steps(0, 11);
    drain();
    end_test();

    start_test("3 physical address over the range");
    for (int a = 0; a < NUMVROW; a++) issue_read(1, a, ref_data[1][a], ref_err[1][a]);
    for (int a = NUMVROW - 1; a >= 0; a -= 7) issue_read(0, a, ref_data[0][a], ref_err[0][a]);
    idle();
    drain();
    end_test();

    start_test("4 parity error injection");
    apply_steps(12, 21);
    drain();
    end_test();

    start_test("5 scrub sweep");
    @(posedge clk);
    scrub_en <= 1'b1;
    run_sweep(1'b0);
    check_scrub();
    @(posedge clk);
    scrub_en <= 1'b0;
    repeat (3) idle();
    end_test();

    start_test("6 scrub sweep with host reads");
    @(posedge clk);
    scrub_en <= 1'b1;
    run_sweep(1'b1);
    check_scrub();
    @(posedge clk);
    scrub_en <= 1'b0;
    end_test();

    $display("%0d checks run, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
pseudo_pkg.sv
np2_addr.sv
align_pseudo.sv
read_arbiter.sv
parity_scrubber.sv
row_sram.sv
scrub_mem_top.sv
tb_scrub_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_scrub_mem
RTL_TOP   ?= scrub_mem_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
